// File: soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// apb bus widths
`define APB_AW 32
`define APB_DW 32

// address map
`define ROM_BASE   32'h0001_0000
`define ROM_LEN    32'h0000_1000
`define CLINT_BASE 32'h0200_0000
`define CLINT_LEN  32'h0000_C000
`define PLIC_BASE  32'h0C00_0000
`define PLIC_LEN   32'h0400_0000

// interrupt sources, source 0 never pends
`define NUM_SOURCES 8
`define PRIO_W      3

// boot image depth in words
`define ROM_WORDS 8

`endif

// File: soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

  // address regions seen by the decoder
  // unmapped addresses fall into NONE
  typedef enum logic [1:0] {
    ROM   = 2'd0,
    CLINT = 2'd1,
    PLIC  = 2'd2,
    NONE  = 2'd3
  } region_e;

endpackage

`default_nettype wire

// File: periph_pkg.sv
`default_nettype none

`include "soc_config.svh"

package periph_pkg;

  // clint register offsets
  typedef enum logic [$clog2(`CLINT_LEN)-1:0] {
    MSIP        = 'h0000,
    MTIMECMP_LO = 'h4000,
    MTIMECMP_HI = 'h4004,
    MTIME_LO    = 'hBFF8,
    MTIME_HI    = 'hBFFC,
    CLINT_NONE  = 'hFFFF
  } clint_reg_e;

  // plic register offsets
  // PRIORITY starts a block of one word per source
  typedef enum logic [$clog2(`PLIC_LEN)-1:0] {
    PRIORITY  = 'h000_0000,
    PENDING   = 'h000_1000,
    ENABLE    = 'h000_2000,
    THRESHOLD = 'h020_0000,
    CLAIM     = 'h020_0004,
    PLIC_NONE = 'h3FF_FFFF
  } plic_reg_e;

  // level gateway, one per source
  typedef enum logic {
    IDLE    = 1'b0,
    CLAIMED = 1'b1
  } gw_state_e;

  localparam logic [`APB_DW-1:0] boot_image [`ROM_WORDS] = '{
    32'hF140_2573,
    32'h0000_0597,
    32'h0185_8593,
    32'h0010_0293,
    32'h1050_0073,
    32'hFFDF_F06F,
    32'h0000_0013,
    32'hDEAD_BEEF
  };

endpackage

`default_nettype wire

// File: apb_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

interface apb_if;

  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [`APB_AW-1:0] paddr;
  logic [`APB_DW-1:0] pwdata;
  logic [`APB_DW-1:0] prdata;
  logic               pready;
  logic               pslverr;

  modport requester (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  modport completer (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

`default_nettype wire

// File: periph_apb_demux.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module periph_apb_demux (
  apb_if.completer up,
  apb_if.requester rom_o,
  apb_if.requester clint_o,
  apb_if.requester plic_o
);

  soc_map_pkg::region_e region;
  logic [`APB_AW-1:0]   base;
  logic [`APB_AW-1:0]   offset;
  logic                 access;

  // region decode
  always_comb begin
    region = soc_map_pkg::NONE;
    base   = '0;
    if (up.paddr >= `ROM_BASE && up.paddr < `ROM_BASE + `ROM_LEN) begin
      region = soc_map_pkg::ROM;
      base   = `ROM_BASE;
    end else if (up.paddr >= `CLINT_BASE && up.paddr < `CLINT_BASE + `CLINT_LEN) begin
      region = soc_map_pkg::CLINT;
      base   = `CLINT_BASE;
    end else if (up.paddr >= `PLIC_BASE && up.paddr < `PLIC_BASE + `PLIC_LEN) begin
      region = soc_map_pkg::PLIC;
      base   = `PLIC_BASE;
    end
  end

  assign offset = up.paddr - base;
  assign access = up.psel & up.penable;

  // ------------------------------------------------
  // requests, psel only toward the selected region
  // ------------------------------------------------
  assign rom_o.psel      = up.psel & (region == soc_map_pkg::ROM);
  assign rom_o.penable   = up.penable;
  assign rom_o.pwrite    = up.pwrite;
  assign rom_o.paddr     = offset;
  assign rom_o.pwdata    = up.pwdata;

  assign clint_o.psel    = up.psel & (region == soc_map_pkg::CLINT);
  assign clint_o.penable = up.penable;
  assign clint_o.pwrite  = up.pwrite;
  assign clint_o.paddr   = offset;
  assign clint_o.pwdata  = up.pwdata;

  assign plic_o.psel     = up.psel & (region == soc_map_pkg::PLIC);
  assign plic_o.penable  = up.penable;
  assign plic_o.pwrite   = up.pwrite;
  assign plic_o.paddr    = offset;
  assign plic_o.pwdata   = up.pwdata;

  // ------------------------------------------------
  // response mux
  // ------------------------------------------------
  always_comb begin
    case (region)
      soc_map_pkg::ROM: begin
        up.prdata  = rom_o.prdata;
        up.pready  = rom_o.pready;
        up.pslverr = rom_o.pslverr;
      end
      soc_map_pkg::CLINT: begin
        up.prdata  = clint_o.prdata;
        up.pready  = clint_o.pready;
        up.pslverr = clint_o.pslverr;
      end
      soc_map_pkg::PLIC: begin
        up.prdata  = plic_o.prdata;
        up.pready  = plic_o.pready;
        up.pslverr = plic_o.pslverr;
      end
      default: begin
        // unmapped, answered here
        up.prdata  = '0;
        up.pready  = access;
        up.pslverr = access;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module boot_rom (
  input  wire logic clk,
  input  wire logic ndmreset_n,
  apb_if.completer  bus
);

  localparam int IDX_W = $clog2(`ROM_WORDS);

  logic [`APB_DW-1:0] word;
  logic [`APB_DW-1:0] prdata_q;
  logic               in_range;

  // word select from offset bits 4:2
  assign in_range = bus.paddr[`APB_AW-1:2] < `ROM_WORDS;
  assign word     = in_range ? periph_pkg::boot_image[bus.paddr[IDX_W+1:2]] : '0;

  // sampled in the setup cycle
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      prdata_q <= '0;
    end else if (bus.psel && !bus.penable) begin
      prdata_q <= word;
    end
  end

  assign bus.prdata  = prdata_q;
  assign bus.pready  = bus.psel & bus.penable;
  assign bus.pslverr = bus.psel & bus.penable & bus.pwrite;

endmodule

`default_nettype wire

// File: clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module clint_timer (
  input  wire logic clk,
  input  wire logic ndmreset_n,
  apb_if.completer  bus,
  output logic      timer_irq_o,
  output logic      ipi_o
);

  localparam int OFF_W = $clog2(`CLINT_LEN);

  periph_pkg::clint_reg_e reg_sel;
  logic                   rtc_q;
  logic [63:0]            mtime_q;
  logic [63:0]            mtimecmp_q;
  logic                   msip_q;
  logic                   wr_en;

  assign wr_en = bus.psel & bus.penable & bus.pwrite;

  always_comb begin
    case (bus.paddr[OFF_W-1:0])
      periph_pkg::MSIP:        reg_sel = periph_pkg::MSIP;
      periph_pkg::MTIMECMP_LO: reg_sel = periph_pkg::MTIMECMP_LO;
      periph_pkg::MTIMECMP_HI: reg_sel = periph_pkg::MTIMECMP_HI;
      periph_pkg::MTIME_LO:    reg_sel = periph_pkg::MTIME_LO;
      periph_pkg::MTIME_HI:    reg_sel = periph_pkg::MTIME_HI;
      default:                 reg_sel = periph_pkg::CLINT_NONE;
    endcase
  end

  // rtc tick, clk divided by two
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_q <= 1'b0;
    end else begin
      rtc_q <= ~rtc_q;
    end
  end

  // a write to either half wins over the tick
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q <= '0;
    end else if (wr_en && reg_sel == periph_pkg::MTIME_LO) begin
      mtime_q[31:0] <= bus.pwdata;
    end else if (wr_en && reg_sel == periph_pkg::MTIME_HI) begin
      mtime_q[63:32] <= bus.pwdata;
    end else if (rtc_q) begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_o <= 1'b0;
    end else begin
      timer_irq_o <= (mtime_q >= mtimecmp_q);
      if (wr_en) begin
        case (reg_sel)
          periph_pkg::MSIP:        msip_q            <= bus.pwdata[0];
          periph_pkg::MTIMECMP_LO: mtimecmp_q[31:0]  <= bus.pwdata;
          periph_pkg::MTIMECMP_HI: mtimecmp_q[63:32] <= bus.pwdata;
          default: ;
        endcase
      end
    end
  end

  assign ipi_o = msip_q;

  always_comb begin
    case (reg_sel)
      periph_pkg::MSIP:        bus.prdata = {{(`APB_DW-1){1'b0}}, msip_q};
      periph_pkg::MTIMECMP_LO: bus.prdata = mtimecmp_q[31:0];
      periph_pkg::MTIMECMP_HI: bus.prdata = mtimecmp_q[63:32];
      periph_pkg::MTIME_LO:    bus.prdata = mtime_q[31:0];
      periph_pkg::MTIME_HI:    bus.prdata = mtime_q[63:32];
      default:                 bus.prdata = '0;
    endcase
  end

  assign bus.pready  = bus.psel & bus.penable;
  assign bus.pslverr = 1'b0;

endmodule

`default_nettype wire

// File: plic_lite.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module plic_lite (
  input  wire logic                    clk,
  input  wire logic                    ndmreset_n,
  apb_if.completer                     bus,
  input  wire logic [`NUM_SOURCES-1:0] irq_sources_i,
  output logic                         eip_o
);

  localparam int OFF_W = $clog2(`PLIC_LEN);
  localparam int ID_W  = $clog2(`NUM_SOURCES);

  periph_pkg::plic_reg_e   reg_sel;
  periph_pkg::gw_state_e   gw_q [`NUM_SOURCES];
  logic [`PRIO_W-1:0]      prio_q [`NUM_SOURCES];
  logic [`NUM_SOURCES-1:0] enable_q;
  logic [`NUM_SOURCES-1:0] pending_q;
  logic [`PRIO_W-1:0]      threshold_q;
  logic [OFF_W-1:0]        offset;
  logic [ID_W-1:0]         reg_id;
  logic [ID_W-1:0]         claim_id;
  logic [ID_W-1:0]         wr_id;
  logic [`PRIO_W-1:0]      best_prio;
  logic                    eip_d;
  logic                    wr_en;
  logic                    claim_rd;
  logic                    complete_wr;

  assign offset = bus.paddr[OFF_W-1:0];
  assign reg_id = offset[ID_W+1:2];
  assign wr_id  = bus.pwdata[ID_W-1:0];

  always_comb begin
    if (offset[OFF_W-1:ID_W+2] == '0 && offset[1:0] == 2'b00) begin
      reg_sel = periph_pkg::PRIORITY;
    end else begin
      case (offset)
        periph_pkg::PENDING:   reg_sel = periph_pkg::PENDING;
        periph_pkg::ENABLE:    reg_sel = periph_pkg::ENABLE;
        periph_pkg::THRESHOLD: reg_sel = periph_pkg::THRESHOLD;
        periph_pkg::CLAIM:     reg_sel = periph_pkg::CLAIM;
        default:               reg_sel = periph_pkg::PLIC_NONE;
      endcase
    end
  end

  assign wr_en       = bus.psel & bus.penable & bus.pwrite;
  assign claim_rd    = bus.psel & bus.penable & ~bus.pwrite & (reg_sel == periph_pkg::CLAIM);
  assign complete_wr = wr_en & (reg_sel == periph_pkg::CLAIM);

  // ------------------------------------------------
  // arbitration, ties go to the lowest id
  // ------------------------------------------------
  always_comb begin
    claim_id  = '0;
    best_prio = '0;
    eip_d     = 1'b0;
    for (int i = 1; i < `NUM_SOURCES; i++) begin
      if (pending_q[i] && enable_q[i]) begin
        if (claim_id == '0 || prio_q[i] > best_prio) begin
          claim_id  = ID_W'(i);
          best_prio = prio_q[i];
        end
        if (prio_q[i] > threshold_q) begin
          eip_d = 1'b1;
        end
      end
    end
  end

  // config registers
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      for (int i = 0; i < `NUM_SOURCES; i++) begin
        prio_q[i] <= '0;
      end
      enable_q    <= '0;
      threshold_q <= '0;
    end else if (wr_en) begin
      case (reg_sel)
        periph_pkg::PRIORITY: begin
          if (reg_id != '0) begin
            prio_q[reg_id] <= bus.pwdata[`PRIO_W-1:0];
          end
        end
        periph_pkg::ENABLE:    enable_q    <= {bus.pwdata[`NUM_SOURCES-1:1], 1'b0};
        periph_pkg::THRESHOLD: threshold_q <= bus.pwdata[`PRIO_W-1:0];
        default: ;
      endcase
    end
  end

  // gateways and pending bits
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      for (int i = 0; i < `NUM_SOURCES; i++) begin
        gw_q[i] <= periph_pkg::IDLE;
      end
      pending_q <= '0;
      eip_o     <= 1'b0;
    end else begin
      eip_o <= eip_d;
      for (int i = 1; i < `NUM_SOURCES; i++) begin
        if (claim_rd && claim_id == ID_W'(i)) begin
          pending_q[i] <= 1'b0;
          gw_q[i]      <= periph_pkg::CLAIMED;
        end else if (complete_wr && wr_id == ID_W'(i)) begin
          gw_q[i] <= periph_pkg::IDLE;
        end else if (irq_sources_i[i] && enable_q[i] && gw_q[i] == periph_pkg::IDLE) begin
          pending_q[i] <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    case (reg_sel)
      periph_pkg::PRIORITY:  bus.prdata = `APB_DW'(prio_q[reg_id]);
      periph_pkg::PENDING:   bus.prdata = `APB_DW'(pending_q);
      periph_pkg::ENABLE:    bus.prdata = `APB_DW'(enable_q);
      periph_pkg::THRESHOLD: bus.prdata = `APB_DW'(threshold_q);
      periph_pkg::CLAIM:     bus.prdata = `APB_DW'(claim_id);
      default:               bus.prdata = '0;
    endcase
  end

  assign bus.pready  = bus.psel & bus.penable;
  assign bus.pslverr = 1'b0;

endmodule

`default_nettype wire

// File: periph_shell.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module periph_shell (
  input  wire logic                    clk,
  input  wire logic                    ndmreset_n,
  input  wire logic                    psel_i,
  input  wire logic                    penable_i,
  input  wire logic                    pwrite_i,
  input  wire logic [`APB_AW-1:0]      paddr_i,
  input  wire logic [`APB_DW-1:0]      pwdata_i,
  input  wire logic [`NUM_SOURCES-1:0] irq_sources_i,
  output logic [`APB_DW-1:0]           prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  output logic                         timer_irq_o,
  output logic                         ipi_o,
  output logic                         eip_o
);

  apb_if up_bus ();
  apb_if rom_bus ();
  apb_if clint_bus ();
  apb_if plic_bus ();

  // ------------------------------------------------
  // upstream apb
  // ------------------------------------------------
  assign up_bus.psel    = psel_i;
  assign up_bus.penable = penable_i;
  assign up_bus.pwrite  = pwrite_i;
  assign up_bus.paddr   = paddr_i;
  assign up_bus.pwdata  = pwdata_i;
  assign prdata_o       = up_bus.prdata;
  assign pready_o       = up_bus.pready;
  assign pslverr_o      = up_bus.pslverr;

  periph_apb_demux i_periph_apb_demux (
    .up      ( up_bus    ),
    .rom_o   ( rom_bus   ),
    .clint_o ( clint_bus ),
    .plic_o  ( plic_bus  )
  );

  // ------------------------------------------------
  // peripherals
  // ------------------------------------------------
  boot_rom i_boot_rom (
    .clk        ( clk        ),
    .ndmreset_n ( ndmreset_n ),
    .bus        ( rom_bus    )
  );

  clint_timer i_clint_timer (
    .clk         ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .bus         ( clint_bus   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  plic_lite i_plic_lite (
    .clk           ( clk           ),
    .ndmreset_n    ( ndmreset_n    ),
    .bus           ( plic_bus      ),
    .irq_sources_i ( irq_sources_i ),
    .eip_o         ( eip_o         )
  );

endmodule

`default_nettype wire

// File: tb_periph_shell.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module tb_periph_shell;

  typedef enum logic [3:0] {
    OP_WRITE, OP_READ, OP_SOURCES, OP_WAIT, OP_SIG,
    OP_IDLE, OP_CAPTURE, OP_READ_GT, OP_WRITE_REL
  } op_e;

  typedef struct {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_data;
    logic        exp_err;
  } entry_t;

  localparam int SIG_IPI   = 0;
  localparam int SIG_TIMER = 1;
  localparam int SIG_EIP   = 2;

  localparam logic [31:0] ALL_SRC  = (32'd1 << `NUM_SOURCES) - 32'd1;
  localparam logic [31:0] SRC_MASK = ALL_SRC & ~32'd1;

  localparam logic [31:0] CLINT_MSIP   = `CLINT_BASE + 32'(periph_pkg::MSIP);
  localparam logic [31:0] CLINT_CMP_LO = `CLINT_BASE + 32'(periph_pkg::MTIMECMP_LO);
  localparam logic [31:0] CLINT_CMP_HI = `CLINT_BASE + 32'(periph_pkg::MTIMECMP_HI);
  localparam logic [31:0] CLINT_MT_LO  = `CLINT_BASE + 32'(periph_pkg::MTIME_LO);
  localparam logic [31:0] PLIC_PRIO    = `PLIC_BASE + 32'(periph_pkg::PRIORITY);
  localparam logic [31:0] PLIC_PEND    = `PLIC_BASE + 32'(periph_pkg::PENDING);
  localparam logic [31:0] PLIC_ENABLE  = `PLIC_BASE + 32'(periph_pkg::ENABLE);
  localparam logic [31:0] PLIC_THRESH  = `PLIC_BASE + 32'(periph_pkg::THRESHOLD);
  localparam logic [31:0] PLIC_CLAIM   = `PLIC_BASE + 32'(periph_pkg::CLAIM);

  logic                    clk;
  logic                    ndmreset_n;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`APB_AW-1:0]      paddr;
  logic [`APB_DW-1:0]      pwdata;
  logic [`NUM_SOURCES-1:0] irq_sources;
  logic [`APB_DW-1:0]      prdata;
  logic                    pready;
  logic                    pslverr;
  logic                    timer_irq;
  logic                    ipi;
  logic                    eip;

  entry_t             stim_q [$];
  logic [15:0]        lfsr_q;
  logic [`PRIO_W-1:0] prio [`NUM_SOURCES];
  logic [`PRIO_W-1:0] max_prio;
  int                 claim_order [`NUM_SOURCES-1];
  logic [31:0]        captured;
  int                 n_checks;
  int                 n_errors;
  int                 cycles;
  int                 cycle_limit;

  periph_shell i_periph_shell (
    .clk           ( clk         ),
    .ndmreset_n    ( ndmreset_n  ),
    .psel_i        ( psel        ),
    .penable_i     ( penable     ),
    .pwrite_i      ( pwrite      ),
    .paddr_i       ( paddr       ),
    .pwdata_i      ( pwdata      ),
    .irq_sources_i ( irq_sources ),
    .prdata_o      ( prdata      ),
    .pready_o      ( pready      ),
    .pslverr_o     ( pslverr     ),
    .timer_irq_o   ( timer_irq   ),
    .ipi_o         ( ipi         ),
    .eip_o         ( eip         )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  function automatic logic sig_value(input logic [31:0] sel);
    case (sel)
      SIG_IPI:   return ipi;
      SIG_TIMER: return timer_irq;
      default:   return eip;
    endcase
  endfunction

  function automatic string sig_name(input logic [31:0] sel);
    case (sel)
      SIG_IPI:   return "ipi_o";
      SIG_TIMER: return "timer_irq_o";
      default:   return "eip_o";
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      n_errors++;
    end
  endtask

  task automatic add_entry(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                           input logic [31:0] exp_data, input logic exp_err);
    entry_t e;
    e.op       = op;
    e.addr     = addr;
    e.data     = data;
    e.exp_data = exp_data;
    e.exp_err  = exp_err;
    stim_q.push_back(e);
  endtask

  // lfsr priorities and the expected claim order
  // highest priority first, lowest id wins a tie
  task automatic build_model();
    logic [31:0]             bits;
    logic [`NUM_SOURCES-1:0] left;
    int                      best;
    lfsr_q   = 16'd58165;
    max_prio = '0;
    prio[0]  = '0;
    for (int id = 1; id < `NUM_SOURCES; id++) begin
      bits     = draw_bits(`PRIO_W);
      prio[id] = bits[`PRIO_W-1:0];
      if (prio[id] > max_prio) begin
        max_prio = prio[id];
      end
    end
    left = SRC_MASK[`NUM_SOURCES-1:0];
    for (int k = 0; k < `NUM_SOURCES - 1; k++) begin
      best = 0;
      for (int id = 1; id < `NUM_SOURCES; id++) begin
        if (left[id] && (best == 0 || prio[id] > prio[best])) begin
          best = id;
        end
      end
      claim_order[k] = best;
      left[best]     = 1'b0;
    end
  endtask

  task automatic build_table();
    logic [31:0] pend;
    int          n_wait;
    // rom and unmapped accesses
    for (int i = 0; i < `ROM_WORDS; i++) begin
      add_entry(OP_READ, `ROM_BASE + 4 * i, 0, periph_pkg::boot_image[i], 1'b0);
    end
    add_entry(OP_READ, `ROM_BASE + 4 * `ROM_WORDS, 0, 0, 1'b0);
    add_entry(OP_READ, `ROM_BASE + `ROM_LEN - 4, 0, 0, 1'b0);
    add_entry(OP_WRITE, `ROM_BASE, 32'h1234_5678, 0, 1'b1);
    add_entry(OP_READ, `ROM_BASE, 0, periph_pkg::boot_image[0], 1'b0);
    add_entry(OP_READ, 32'h3000_0000, 0, 0, 1'b1);
    add_entry(OP_WRITE, 32'h0000_0100, 32'hFFFF_FFFF, 0, 1'b1);
    // software interrupt
    add_entry(OP_WRITE, CLINT_MSIP, 1, 0, 1'b0);
    add_entry(OP_WAIT, SIG_IPI, 1, 0, 1'b0);
    add_entry(OP_READ, CLINT_MSIP, 0, 1, 1'b0);
    add_entry(OP_WRITE, CLINT_MSIP, 0, 0, 1'b0);
    add_entry(OP_WAIT, SIG_IPI, 0, 0, 1'b0);
    add_entry(OP_READ, CLINT_MSIP, 0, 0, 1'b0);
    add_entry(OP_READ, `CLINT_BASE + 32'h8, 0, 0, 1'b0);
    // timer
    // low half of mtimecmp goes first so the compare stays far away
    add_entry(OP_CAPTURE, CLINT_MT_LO, 0, 0, 1'b0);
    add_entry(OP_IDLE, 0, 4, 0, 1'b0);
    add_entry(OP_READ_GT, CLINT_MT_LO, 0, 0, 1'b0);
    add_entry(OP_WRITE_REL, CLINT_CMP_LO, 20, 0, 1'b0);
    add_entry(OP_SIG, SIG_TIMER, 0, 0, 1'b0);
    add_entry(OP_WRITE, CLINT_CMP_HI, 0, 0, 1'b0);
    add_entry(OP_WAIT, SIG_TIMER, 1, 0, 1'b0);
    add_entry(OP_WRITE, CLINT_CMP_HI, 32'hFFFF_FFFF, 0, 1'b0);
    add_entry(OP_WRITE, CLINT_CMP_LO, 32'hFFFF_FFFF, 0, 1'b0);
    add_entry(OP_WAIT, SIG_TIMER, 0, 0, 1'b0);
    add_entry(OP_READ, CLINT_CMP_LO, 0, 32'hFFFF_FFFF, 1'b0);
    // plic routing and claims
    for (int id = 1; id < `NUM_SOURCES; id++) begin
      add_entry(OP_WRITE, PLIC_PRIO + 4 * id, prio[id], 0, 1'b0);
      add_entry(OP_READ, PLIC_PRIO + 4 * id, 0, prio[id], 1'b0);
    end
    add_entry(OP_WRITE, PLIC_THRESH, 0, 0, 1'b0);
    add_entry(OP_WRITE, PLIC_ENABLE, ALL_SRC, 0, 1'b0);
    add_entry(OP_READ, PLIC_ENABLE, 0, SRC_MASK, 1'b0);
    add_entry(OP_SOURCES, 0, ALL_SRC, 0, 1'b0);
    add_entry(OP_WAIT, SIG_EIP, max_prio != 0, 0, 1'b0);
    add_entry(OP_READ, PLIC_PEND, 0, SRC_MASK, 1'b0);
    pend = SRC_MASK;
    for (int k = 0; k < `NUM_SOURCES - 1; k++) begin
      add_entry(OP_READ, PLIC_CLAIM, 0, claim_order[k], 1'b0);
      pend[claim_order[k]] = 1'b0;
      add_entry(OP_READ, PLIC_PEND, 0, pend, 1'b0);
    end
    add_entry(OP_READ, PLIC_CLAIM, 0, 0, 1'b0);
    add_entry(OP_READ, `PLIC_BASE + 32'h3000, 0, 0, 1'b0);
    // threshold and completion with the sources still high
    add_entry(OP_WRITE, PLIC_THRESH, max_prio, 0, 1'b0);
    for (int id = 1; id < `NUM_SOURCES; id++) begin
      add_entry(OP_WRITE, PLIC_CLAIM, id, 0, 1'b0);
    end
    add_entry(OP_IDLE, 0, 4, 0, 1'b0);
    add_entry(OP_READ, PLIC_PEND, 0, SRC_MASK, 1'b0);
    add_entry(OP_SIG, SIG_EIP, 0, 0, 1'b0);
    pend = SRC_MASK;
    pend[claim_order[0]] = 1'b0;
    add_entry(OP_READ, PLIC_CLAIM, 0, claim_order[0], 1'b0);
    add_entry(OP_READ, PLIC_PEND, 0, pend, 1'b0);
    add_entry(OP_IDLE, 0, 4, 0, 1'b0);
    add_entry(OP_READ, PLIC_PEND, 0, pend, 1'b0);
    add_entry(OP_WRITE, PLIC_CLAIM, claim_order[0], 0, 1'b0);
    add_entry(OP_READ, PLIC_PEND, 0, SRC_MASK, 1'b0);
    add_entry(OP_SIG, SIG_EIP, 0, 0, 1'b0);
    add_entry(OP_WRITE, PLIC_THRESH, 0, 0, 1'b0);
    add_entry(OP_WAIT, SIG_EIP, max_prio != 0, 0, 1'b0);
    add_entry(OP_SOURCES, 0, 0, 0, 1'b0);
    n_wait = 0;
    foreach (stim_q[i]) begin
      if (stim_q[i].op == OP_WAIT) begin
        n_wait++;
      end
    end
    cycle_limit = 16 + 4 * stim_q.size() + 64 * n_wait;
  endtask

  // --------------------------------------------------
  // apb transfer and table entries
  // --------------------------------------------------
  task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int waited;
    waited = 0;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    while (!pready && waited < 16) begin
      waited++;
      @(posedge clk);
    end
    if (!pready) begin
      $display("no pready from the DUT for the transfer at address 0x%08h", addr);
      n_errors++;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic wait_signal(input logic [31:0] sel, input logic level);
    int waited;
    waited = 0;
    @(posedge clk);
    while (sig_value(sel) !== level && waited < 64) begin
      waited++;
      @(posedge clk);
    end
    if (sig_value(sel) !== level) begin
      $display("%s did not reach %0d within 64 cycles", sig_name(sel), level);
      n_errors++;
    end
  endtask

  task automatic run_entry(input entry_t e);
    logic [31:0] rdata;
    logic        err;
    case (e.op)
      OP_WRITE, OP_WRITE_REL: begin
        apb_xfer(1'b1, e.addr, (e.op == OP_WRITE_REL) ? captured + e.data : e.data, rdata, err);
        check("pslverr_o", err, e.exp_err);
      end
      OP_READ, OP_CAPTURE, OP_READ_GT: begin
        apb_xfer(1'b0, e.addr, 0, rdata, err);
        check("pslverr_o", err, e.exp_err);
        if (e.op == OP_READ) begin
          check("prdata_o", rdata, e.exp_data);
        end else if (e.op == OP_READ_GT) begin
          check("prdata_o above previous mtime", rdata > captured, 1);
        end
        captured = rdata;
      end
      OP_SOURCES: begin
        @(negedge clk);
        irq_sources = e.data[`NUM_SOURCES-1:0];
      end
      OP_WAIT: wait_signal(e.addr, e.data[0]);
      OP_SIG: begin
        @(posedge clk);
        check(sig_name(e.addr), sig_value(e.addr), e.data);
      end
      OP_IDLE: repeat (e.data) @(negedge clk);
      default: ;
    endcase
  endtask

  initial begin
    ndmreset_n  = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    irq_sources = '0;
    captured    = '0;
    n_checks    = 0;
    n_errors    = 0;
    cycles      = 0;
    cycle_limit = 0;
    build_model();
    build_table();
    repeat (16) @(posedge clk);
    @(negedge clk);
    ndmreset_n = 1'b1;
    foreach (stim_q[i]) begin
      run_entry(stim_q[i]);
    end
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
soc_map_pkg.sv
periph_pkg.sv
apb_if.sv
periph_apb_demux.sv
boot_rom.sv
clint_timer.sv
plic_lite.sv
periph_shell.sv
tb_periph_shell.sv

// File: Bender.yml
package:
  name: periph_shell

export_include_dirs:
  - .

sources:
  - soc_map_pkg.sv
  - periph_pkg.sv
  - apb_if.sv
  - periph_apb_demux.sv
  - boot_rom.sv
  - clint_timer.sv
  - plic_lite.sv
  - periph_shell.sv
  - target: simulation
    files:
      - tb_periph_shell.sv
